/* hw/rv32_pkg.sv */
package rv32_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // memory geometry
    // ~~~~~~~~~~~~~~~~~~~~

    localparam int DMEM_WORDS     = 256;
    localparam int DMEM_ADDR_BITS = 8; // word index, address bits 9:2.

    // ~~~~~~~~~~~~~~~~~~~~
    // opcodes
    // ~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_SUB = 2'b01,
        ALU_SLT = 2'b10 // signed compare.
    } alu_op_t;

    typedef enum logic [1:0] {
        BRANCH_NEVER    = 2'b00,
        BRANCH_ZERO     = 2'b01,
        BRANCH_NON_ZERO = 2'b10,
        BRANCH_ALWAYS   = 2'b11
    } branch_op_t;

    typedef enum logic [1:0] {
        WIDTH_WORD = 2'b00,
        WIDTH_HALF = 2'b01,
        WIDTH_BYTE = 2'b10
    } mem_width_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // pipeline records
    // ~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic        valid;
        alu_op_t     alu_op;
        logic [31:0] operand_a;
        logic [31:0] operand_b;
        logic [31:0] store_value;
        logic [31:0] pc;
        logic [31:0] imm;
        logic        read_en;
        logic        write_en;
        mem_width_t  width;
        logic        zero_extend;
        branch_op_t  branch_op;
        logic [4:0]  rd;
        logic        rd_writeback;
    } issue_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] result;      // alu result, also the memory address.
        logic [31:0] store_value;
        logic [31:0] branch_pc;
        logic        read_en;
        logic        write_en;
        mem_width_t  width;
        logic        zero_extend;
        branch_op_t  branch_op;
        logic [4:0]  rd;
        logic        rd_writeback;
    } ex_mem_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic        rd_writeback;
        logic [31:0] rd_value;
    } wb_t;

endpackage

/* hw/rv32_branch.sv */
module rv32_branch
    import rv32_pkg::*;
(
    input  branch_op_t  op,
    input  logic [31:0] result,
    output logic        taken
);

    logic result_zero;

    assign result_zero = (result == 32'd0);

    always_comb begin
        case (op)
            BRANCH_NEVER:    taken = 1'b0;
            BRANCH_ZERO:     taken = result_zero;  // beq style, result is a - b.
            BRANCH_NON_ZERO: taken = !result_zero; // bne, and blt via slt.
            BRANCH_ALWAYS:   taken = 1'b1;         // jumps.
            default:         taken = 1'b0;
        endcase
    end

endmodule

/* hw/rv32_execute.sv */
module rv32_execute
    import rv32_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    stall,
    input  logic    flush,
    input  issue_t  issue,
    output ex_mem_t ex_mem
);

    logic [31:0] alu_result;
    ex_mem_t     ex_next;

    // ~~~~~~~~~~~~~~~~~~~~
    // alu
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (issue.alu_op)
            ALU_ADD: alu_result = issue.operand_a + issue.operand_b;
            ALU_SUB: alu_result = issue.operand_a - issue.operand_b;
            ALU_SLT: alu_result = ($signed(issue.operand_a) < $signed(issue.operand_b)) ?
                                  32'd1 : 32'd0;
            default: alu_result = 32'd0;
        endcase
    end

    always_comb begin
        ex_next.valid        = issue.valid && !flush; // taken branch kills this slot.
        ex_next.result       = alu_result;
        ex_next.store_value  = issue.store_value;
        ex_next.branch_pc    = issue.pc + issue.imm;
        ex_next.read_en      = issue.read_en;
        ex_next.write_en     = issue.write_en;
        ex_next.width        = issue.width;
        ex_next.zero_extend  = issue.zero_extend;
        ex_next.branch_op    = issue.branch_op;
        ex_next.rd           = issue.rd;
        ex_next.rd_writeback = issue.rd_writeback;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // ex/mem register
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.valid <= 1'b0;
        end else if (!stall) begin
            ex_mem <= ex_next;
        end
    end

    a_no_read_write: assert property (
        @(posedge clk) disable iff (rst)
        ex_mem.valid |-> !(ex_mem.read_en && ex_mem.write_en)
    ) else $error("load and store set in one ex/mem entry");

endmodule

/* hw/rv32_mem.sv */
module rv32_mem
    import rv32_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  logic        flush,
    input  ex_mem_t     ex_mem,
    input  logic [31:0] read_value,
    output logic        branch_taken,
    output logic [31:0] branch_pc,
    output logic [31:0] address,
    output logic [31:0] write_value,
    output logic [3:0]  write_mask,
    output wb_t         writeback
);

    logic        cond_taken;
    logic [15:0] half_lane;
    logic [7:0]  byte_lane;
    logic [31:0] load_value;
    logic [31:0] rd_value;

    rv32_branch branch (
        .op     (ex_mem.branch_op),
        .result (ex_mem.result),
        .taken  (cond_taken)
    );

    assign branch_taken = ex_mem.valid && cond_taken; // no branches from bubbles.
    assign branch_pc    = ex_mem.branch_pc;
    assign address      = ex_mem.result;

    // ~~~~~~~~~~~~~~~~~~~~
    // store lanes
    // ~~~~~~~~~~~~~~~~~~~~

    // data is copied to every lane and the mask picks the one that lands.
    always_comb begin
        write_value = ex_mem.store_value;
        write_mask  = 4'b0000;
        case (ex_mem.width)
            WIDTH_WORD: begin
                write_mask = 4'b1111;
            end
            WIDTH_HALF: begin
                write_value = {2{ex_mem.store_value[15:0]}};
                write_mask  = ex_mem.result[1] ? 4'b0011 : 4'b1100;
            end
            WIDTH_BYTE: begin
                write_value = {4{ex_mem.store_value[7:0]}};
                write_mask  = 4'b1000 >> ex_mem.result[1:0]; // offset 0 is the top byte.
            end
            default: begin
                write_mask = 4'b0000;
            end
        endcase
        if (!(ex_mem.valid && ex_mem.write_en)) begin
            write_mask = 4'b0000;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // load extract
    // ~~~~~~~~~~~~~~~~~~~~

    assign half_lane = ex_mem.result[1] ? read_value[15:0] : read_value[31:16];

    always_comb begin
        case (ex_mem.result[1:0])
            2'b00:   byte_lane = read_value[31:24];
            2'b01:   byte_lane = read_value[23:16];
            2'b10:   byte_lane = read_value[15:8];
            default: byte_lane = read_value[7:0];
        endcase
    end

    always_comb begin
        case (ex_mem.width)
            WIDTH_HALF: load_value = {{16{!ex_mem.zero_extend && half_lane[15]}}, half_lane};
            WIDTH_BYTE: load_value = {{24{!ex_mem.zero_extend && byte_lane[7]}}, byte_lane};
            default:    load_value = read_value;
        endcase
    end

    assign rd_value = ex_mem.read_en ? load_value : ex_mem.result;

    // ~~~~~~~~~~~~~~~~~~~~
    // mem/wb register
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            writeback.valid <= 1'b0;
        end else if (!stall) begin
            writeback.valid        <= ex_mem.valid;
            writeback.rd           <= ex_mem.rd;
            writeback.rd_writeback <= ex_mem.rd_writeback && !flush;
            writeback.rd_value     <= rd_value;
        end
    end

    a_mask_legal: assert property (
        @(posedge clk) disable iff (rst)
        (write_mask == 4'b1111) |-> (address[1:0] == 2'b00)
    ) else $error("word write mask %b at unaligned address %h", write_mask, address);

    a_half_aligned: assert property (
        @(posedge clk) disable iff (rst)
        (ex_mem.valid && (ex_mem.read_en || ex_mem.write_en) && ex_mem.width == WIDTH_HALF)
            |-> !ex_mem.result[0]
    ) else $error("misaligned half access at %h", ex_mem.result);

endmodule

/* hw/rv32_dmem.sv */
module rv32_dmem
    import rv32_pkg::*;
(
    input  logic        clk,
    input  logic [31:0] address,
    input  logic [31:0] write_value,
    input  logic [3:0]  write_mask,
    output logic [31:0] read_value
);

    logic [31:0]               mem [DMEM_WORDS];
    logic [DMEM_ADDR_BITS-1:0] index;

    assign index      = address[DMEM_ADDR_BITS+1:2]; // byte offset dropped.
    assign read_value = mem[index];                  // async read.

    // mask bit i covers bits 8*i+7 down to 8*i.
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (write_mask[i]) begin
                mem[index][8*i +: 8] <= write_value[8*i +: 8];
            end
        end
    end

endmodule

/* hw/rv32_mem_path.sv */
module rv32_mem_path
    import rv32_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  logic        flush,
    input  issue_t      issue,
    output wb_t         writeback,
    output logic        branch_taken,
    output logic [31:0] branch_pc
);

    ex_mem_t     ex_mem;
    logic [31:0] address;
    logic [31:0] write_value;
    logic [31:0] read_value;
    logic [3:0]  write_mask;

    // a taken branch flushes the slot being issued.
    rv32_execute execute (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .flush  (branch_taken),
        .issue  (issue),
        .ex_mem (ex_mem)
    );

    rv32_mem mem (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .flush        (flush),
        .ex_mem       (ex_mem),
        .read_value   (read_value),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc),
        .address      (address),
        .write_value  (write_value),
        .write_mask   (write_mask),
        .writeback    (writeback)
    );

    rv32_dmem dmem (
        .clk         (clk),
        .address     (address),
        .write_value (write_value),
        .write_mask  (write_mask),
        .read_value  (read_value)
    );

endmodule

/* tests/rv32_mem_path_tb.sv */
module rv32_mem_path_tb
    import rv32_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam issue_t BUBBLE      = '0;
    localparam int     MIX_OPS     = 80;
    localparam int     FLUSH_OPS   = 20;
    localparam int     ISSUE_COUNT = DMEM_WORDS + 4 * MIX_OPS + FLUSH_OPS;
    localparam int     CYCLE_LIMIT = ISSUE_COUNT * 4 + 100;

    logic        clk = 1'b0;
    logic        rst;
    logic        stall;
    logic        flush;
    issue_t      issue;
    wb_t         writeback;
    logic        branch_taken;
    logic [31:0] branch_pc;

    logic [7:0] model_mem [1024]; // byte 0 of a word is its top byte.
    issue_t     slot       = '0;  // model copy of the ex/mem entry.
    logic       slot_valid = 1'b0;
    logic       wb_due     = 1'b0;
    wb_t        exp_q [$];
    string      test_name  = "reset";
    int         errors     = 0;
    int         checks     = 0;
    int         cycles     = 0;

    rv32_mem_path dut (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .flush        (flush),
        .issue        (issue),
        .writeback    (writeback),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc)
    );

    always #4 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] alu_result(issue_t op);
        case (op.alu_op)
            ALU_SUB: return op.operand_a - op.operand_b;
            ALU_SLT: return {31'd0, $signed(op.operand_a) < $signed(op.operand_b)};
            default: return op.operand_a + op.operand_b;
        endcase
    endfunction

    function automatic logic branch_decision(branch_op_t op, logic [31:0] result);
        return (op == BRANCH_ALWAYS) || (op == BRANCH_ZERO && result == 32'd0) ||
               (op == BRANCH_NON_ZERO && result != 32'd0);
    endfunction

    function automatic logic [31:0] load_value(logic [9:0] a, mem_width_t width, logic zx);
        logic [31:0] word;
        logic [15:0] half;
        logic [7:0]  one;
        word = {model_mem[{a[9:2], 2'd0}], model_mem[{a[9:2], 2'd1}],
                model_mem[{a[9:2], 2'd2}], model_mem[{a[9:2], 2'd3}]};
        half = {model_mem[{a[9:1], 1'b0}], model_mem[{a[9:1], 1'b1}]};
        one  = model_mem[a];
        case (width)
            WIDTH_HALF: return zx ? {16'd0, half} : {{16{half[15]}}, half};
            WIDTH_BYTE: return zx ? {24'd0, one} : {{24{one[7]}}, one};
            default:    return word;
        endcase
    endfunction

    task automatic store_bytes(logic [9:0] a, mem_width_t width, logic [31:0] v);
        case (width)
            WIDTH_WORD: begin
                model_mem[{a[9:2], 2'd0}] = v[31:24];
                model_mem[{a[9:2], 2'd1}] = v[23:16];
                model_mem[{a[9:2], 2'd2}] = v[15:8];
                model_mem[{a[9:2], 2'd3}] = v[7:0];
            end
            WIDTH_HALF: begin
                model_mem[{a[9:1], 1'b0}] = v[15:8];
                model_mem[{a[9:1], 1'b1}] = v[7:0];
            end
            default: model_mem[a] = v[7:0];
        endcase
    endtask

    // inputs seen here are still last cycle's values, which the dut registers too.
    always @(posedge clk) begin
        logic [31:0] result;
        logic        taken;
        wb_t         rec;
        if (rst) begin
            slot_valid = 1'b0;
            wb_due     = 1'b0;
            exp_q.delete();
        end else if (!stall) begin
            taken  = 1'b0;
            wb_due = slot_valid;
            if (slot_valid) begin
                result           = alu_result(slot);
                taken            = branch_decision(slot.branch_op, result);
                rec.valid        = 1'b1;
                rec.rd           = slot.rd;
                rec.rd_writeback = slot.rd_writeback && !flush;
                rec.rd_value     = slot.read_en ?
                                   load_value(result[9:0], slot.width, slot.zero_extend) : result;
                if (slot.write_en) begin
                    store_bytes(result[9:0], slot.width, slot.store_value);
                end
                exp_q.push_back(rec);
            end
            slot_valid = issue.valid && !taken; // issue in a taken cycle is dropped.
            slot       = issue;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // scoreboard
    // ~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin
        wb_t  expected;
        logic exp_taken;
        if (!rst) begin
            exp_taken = slot_valid && branch_decision(slot.branch_op, alu_result(slot));
            checks++;
            if (branch_taken !== exp_taken) begin
                $display("FAILED %s: branch_taken expected %b actual %b",
                         test_name, exp_taken, branch_taken);
                errors++;
            end else if (exp_taken && branch_pc !== slot.pc + slot.imm) begin
                $display("FAILED %s: branch_pc expected %h actual %h",
                         test_name, slot.pc + slot.imm, branch_pc);
                errors++;
            end
            if (!stall) begin
                if (writeback.valid !== wb_due) begin
                    $display("FAILED %s: writeback valid expected %b actual %b",
                             test_name, wb_due, writeback.valid);
                    errors++;
                end
                if (writeback.valid === 1'b1) begin
                    if (exp_q.size() == 0) begin
                        $display("writeback record appeared with none expected in %s",
                                 test_name);
                        errors++;
                    end else begin
                        expected = exp_q.pop_front();
                        checks++;
                        if (writeback !== expected) begin
                            $display("FAILED %s: writeback expected %h actual %h",
                                     test_name, expected, writeback);
                            errors++;
                        end
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~

    // kind 0 alu, 1 store, 2 load, 3 branch.
    function automatic issue_t random_instr(int kind);
        issue_t     op;
        logic [9:0] addr;
        op              = '0;
        op.valid        = 1'b1;
        op.alu_op       = alu_op_t'(2'($urandom_range(0, 2)));
        op.operand_a    = $urandom;
        op.operand_b    = $urandom;
        op.store_value  = $urandom;
        op.pc           = $urandom;
        op.imm          = $urandom;
        op.zero_extend  = 1'($urandom);
        op.rd           = 5'($urandom);
        op.rd_writeback = 1'b1;
        if (kind == 1 || kind == 2) begin
            op.width        = mem_width_t'(2'($urandom_range(0, 2)));
            addr            = {4'd0, 6'($urandom)}; // small window so loads meet stores.
            addr[0]         = addr[0] && op.width == WIDTH_BYTE;
            addr[1]         = addr[1] && op.width != WIDTH_WORD;
            op.alu_op       = ALU_ADD;
            op.operand_b    = {22'($urandom), addr} - op.operand_a;
            op.write_en     = (kind == 1);
            op.read_en      = (kind == 2);
            op.rd_writeback = (kind == 2);
        end else if (kind == 3) begin
            op.alu_op       = ALU_SUB;
            op.branch_op    = branch_op_t'(2'($urandom));
            op.operand_b    = $urandom_range(0, 1) ? op.operand_b : op.operand_a;
            op.rd_writeback = 1'($urandom);
        end
        return op;
    endfunction

    task automatic drive_cycle(issue_t op, logic stall_now, logic flush_now);
        @(posedge clk);
        issue <= op;
        stall <= stall_now;
        flush <= flush_now;
    endtask

    // four bubbles empty the two-cycle pipeline.
    task automatic drain_pipeline();
        repeat (4) begin
            drive_cycle(BUBBLE, 1'b0, 1'b0);
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected records never retired in %s", exp_q.size(), test_name);
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic mix(string name, int lo, int hi, int max_stall);
        test_name = name;
        for (int i = 0; i < MIX_OPS; i++) begin
            repeat ($urandom_range(0, max_stall)) begin
                drive_cycle(BUBBLE, 1'b1, 1'b0);
            end
            drive_cycle(random_instr($urandom_range(lo, hi)), 1'b0, 1'b0);
        end
        drain_pipeline();
    endtask

    initial begin
        issue_t     op;
        logic [7:0] w8;
        void'($urandom(32'h45b0_24ae));
        rst   = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        issue = BUBBLE;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (branch_taken !== 1'b0 || writeback.valid !== 1'b0) begin
            $display("FAILED reset: expected 0 0 actual %b %b", branch_taken, writeback.valid);
            errors++;
        end
        drain_pipeline();

        test_name = "fill";
        for (int w = 0; w < DMEM_WORDS; w++) begin
            w8             = 8'(w);
            op             = random_instr(1);
            op.width       = WIDTH_WORD;
            op.operand_b   = {22'd0, w8, 2'b00} - op.operand_a;
            op.store_value = {w8, ~w8, w8 ^ 8'ha5, w8 + 8'h3c};
            drive_cycle(op, 1'b0, 1'b0);
        end
        drain_pipeline();

        mix("alu", 0, 0, 0);
        mix("load_store", 1, 2, 0);
        mix("branch", 0, 3, 0);
        mix("stall", 0, 3, 2);

        test_name = "flush";
        for (int i = 0; i < FLUSH_OPS; i++) begin
            drive_cycle(BUBBLE, 1'b0, 1'b0);
            drive_cycle(random_instr(0), 1'b0, 1'b0);
            drive_cycle(BUBBLE, 1'b0, 1'b1);
        end
        drain_pipeline();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* rv32_mem_path.f */
hw/rv32_pkg.sv
hw/rv32_branch.sv
hw/rv32_execute.sv
hw/rv32_mem.sv
hw/rv32_dmem.sv
hw/rv32_mem_path.sv
tests/rv32_mem_path_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv32_mem_path_tb
FILELIST  ?= rv32_mem_path.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= TESTS PASSED

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
